//--- source/isa_pkg.sv
// instruction-set widths and encodings, imported by decode, register file and ALU logic
package isa_pkg;

    // ----------------------------------------------------------
    // widths and register count
    // ----------------------------------------------------------
    localparam int REG_COUNT  = 32;   // register 0 reads as zero
    localparam int REG_ADDR_W = 5;
    localparam int DATA_W     = 32;
    localparam int INSTR_W    = 32;
    localparam int OP_W       = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int ALU_OP_W   = 6;    // same width as the alu_op field of the control bundle

    // field positions inside the instruction word
    localparam int OP_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

    // ----------------------------------------------------------
    // encodings
    // ----------------------------------------------------------
    typedef enum logic [OP_W-1:0] {
        RTYPE = 6'h00,
        ADDI  = 6'h08,
        SLTI  = 6'h0a,
        ANDI  = 6'h0c,
        ORI   = 6'h0d,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcode_e;

    // function field of R-type words, bits 5:0
    typedef enum logic [FUNCT_W-1:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        XOR = 6'h26,
        SLT = 6'h2a
    } funct_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 6'd0,   // zero value, so a bubble decodes as an add
        ALU_SUB = 6'd1,
        ALU_AND = 6'd2,
        ALU_OR  = 6'd3,
        ALU_XOR = 6'd4,
        ALU_SLT = 6'd5
    } alu_op_e;

endpackage

//--- source/pipe_pkg.sv
// bundles passed between the issue, pipeline register and execute stages
package pipe_pkg;

    import isa_pkg::*;

    // ----------------------------------------------------------
    // control for one instruction, all zero is a bubble
    // ----------------------------------------------------------
    typedef struct packed {
        logic    reg_wr;
        logic    mem_to_reg;
        logic    mem_wr;
        alu_op_e alu_op;
        logic    alu_src;     // second operand from sign_imm
        logic    reg_dst;     // destination is rd, else rt
    } ex_ctrl_t;

    // one instruction entering execute
    typedef struct packed {
        ex_ctrl_t              ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     r_data_p1;
        logic [DATA_W-1:0]     r_data_p2;
        logic [DATA_W-1:0]     sign_imm;
    } ex_bundle_t;

    // write-back register contents
    typedef struct packed {
        logic                  reg_wr;
        logic                  mem_to_reg;
        logic                  mem_wr;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;      // alu result or memory address
        logic [DATA_W-1:0]     store_data;
    } wb_bundle_t;

endpackage

//--- source/reg_file.sv
// two-read one-write register file with same-cycle write bypass, used by the issue stage
`timescale 1ns/1ns

module reg_file
    (
        input  logic                          clk,
        input  logic                          reset,
        input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
        input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
        output logic [isa_pkg::DATA_W-1:0]     rd_data_a_o,
        output logic [isa_pkg::DATA_W-1:0]     rd_data_b_o,
        input  logic                          wr_en_i,
        input  logic [isa_pkg::REG_ADDR_W-1:0] wr_addr_i,
        input  logic [isa_pkg::DATA_W-1:0]     wr_data_i
    );

    import isa_pkg::*;

    logic [DATA_W-1:0] regs [REG_COUNT];
    logic              wr_live;

    assign wr_live = wr_en_i && (wr_addr_i != '0);   // register 0 is never written

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_live)
        begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // ----------------------------------------------------------
    // read ports, a pending write shows through
    // ----------------------------------------------------------
    always_comb
    begin
        if (wr_live && (wr_addr_i == rd_addr_a_i))
            rd_data_a_o = wr_data_i;
        else
            rd_data_a_o = regs[rd_addr_a_i];

        if (wr_live && (wr_addr_i == rd_addr_b_i))
            rd_data_b_o = wr_data_i;
        else
            rd_data_b_o = regs[rd_addr_b_i];
    end

endmodule

//--- source/issue_stage.sv
// issue stage: decodes the instruction word and reads its operands into an execute bundle
`timescale 1ns/1ns

module issue_stage
    (
        input  logic                          clk,
        input  logic                          reset,
        input  logic [isa_pkg::INSTR_W-1:0]   instr_i,
        input  pipe_pkg::wb_bundle_t          wb_i,
        output pipe_pkg::ex_bundle_t          ex_o
    );

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [IMM_W-1:0]      imm;
    logic [DATA_W-1:0]     rd_data_a;
    logic [DATA_W-1:0]     rd_data_b;
    ex_ctrl_t              ctrl;

    // ----------------------------------------------------------
    // field split
    // ----------------------------------------------------------
    assign opcode = opcode_e'(instr_i[OP_LSB +: OP_W]);
    assign funct  = funct_e'(instr_i[FUNCT_W-1:0]);
    assign rs     = instr_i[RS_LSB +: REG_ADDR_W];
    assign rt     = instr_i[RT_LSB +: REG_ADDR_W];
    assign rd     = instr_i[RD_LSB +: REG_ADDR_W];
    assign imm    = instr_i[IMM_W-1:0];

    // ----------------------------------------------------------
    // control decode, unknown words stay a bubble
    // ----------------------------------------------------------
    always_comb
    begin
        ctrl = '0;
        case (opcode)
            RTYPE:
            begin
                ctrl.reg_wr  = 1'b1;
                ctrl.reg_dst = 1'b1;
                case (funct)
                    ADD:     ctrl.alu_op = ALU_ADD;
                    SUB:     ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    XOR:     ctrl.alu_op = ALU_XOR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    default: ctrl = '0;      // includes the all-zero nop word
                endcase
            end
            ADDI, ANDI, ORI, SLTI:
            begin
                ctrl.reg_wr  = 1'b1;
                ctrl.alu_src = 1'b1;
                case (opcode)
                    ANDI:    ctrl.alu_op = ALU_AND;
                    ORI:     ctrl.alu_op = ALU_OR;
                    SLTI:    ctrl.alu_op = ALU_SLT;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            LW:
            begin
                ctrl.reg_wr     = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;   // address = rs + imm
            end
            SW:
            begin
                ctrl.mem_wr  = 1'b1;
                ctrl.alu_src = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // write port follows the write-back register, loads are not written here
    reg_file u_reg_file
        (
            .clk         (clk),
            .reset       (reset),
            .rd_addr_a_i (rs),
            .rd_addr_b_i (rt),
            .rd_data_a_o (rd_data_a),
            .rd_data_b_o (rd_data_b),
            .wr_en_i     (wb_i.reg_wr && !wb_i.mem_to_reg),
            .wr_addr_i   (wb_i.dest),
            .wr_data_i   (wb_i.result)
        );

    always_comb
    begin
        ex_o.ctrl      = ctrl;
        ex_o.rs        = rs;
        ex_o.rt        = rt;
        ex_o.rd        = rd;
        ex_o.r_data_p1 = rd_data_a;
        ex_o.r_data_p2 = rd_data_b;
        ex_o.sign_imm  = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    end

endmodule

//--- source/ex_pipe_reg.sv
// issue-to-execute pipeline register, cleared on reset or by a synchronous flush
`timescale 1ns/1ns

module ex_pipe_reg
    (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 clr_i,
        input  pipe_pkg::ex_bundle_t ex_i,
        output pipe_pkg::ex_bundle_t ex_o
    );

    // a cleared entry is a bubble
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ex_o <= '0;
        end
        else if (clr_i)
        begin
            ex_o <= '0;      // drops the instruction offered this cycle
        end
        else
        begin
            ex_o <= ex_i;
        end
    end

endmodule

//--- source/exec_stage.sv
// execute stage: forwards operands, runs the ALU and holds the write-back register
`timescale 1ns/1ns

module exec_stage
    (
        input  logic                 clk,
        input  logic                 reset,
        input  pipe_pkg::ex_bundle_t ex_i,
        output pipe_pkg::wb_bundle_t wb_o
    );

    import isa_pkg::*;
    import pipe_pkg::*;

    logic              wb_writes;
    logic              fwd_a;
    logic              fwd_b;
    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] rt_val;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] alu_res;
    wb_bundle_t        wb_d;

    // ----------------------------------------------------------
    // forwarding from the write-back register
    // ----------------------------------------------------------
    assign wb_writes = wb_o.reg_wr && !wb_o.mem_to_reg && (wb_o.dest != '0);
    assign fwd_a     = wb_writes && (wb_o.dest == ex_i.rs);
    assign fwd_b     = wb_writes && (wb_o.dest == ex_i.rt);

    assign opnd_a = fwd_a ? wb_o.result : ex_i.r_data_p1;
    assign rt_val = fwd_b ? wb_o.result : ex_i.r_data_p2;
    assign opnd_b = ex_i.ctrl.alu_src ? ex_i.sign_imm : rt_val;

    // ----------------------------------------------------------
    // alu
    // ----------------------------------------------------------
    always_comb
    begin
        case (ex_i.ctrl.alu_op)
            ALU_ADD: alu_res = opnd_a + opnd_b;
            ALU_SUB: alu_res = opnd_a - opnd_b;
            ALU_AND: alu_res = opnd_a & opnd_b;
            ALU_OR:  alu_res = opnd_a | opnd_b;
            ALU_XOR: alu_res = opnd_a ^ opnd_b;
            ALU_SLT:
            begin
                // signed compare
                alu_res = {{(DATA_W-1){1'b0}}, ($signed(opnd_a) < $signed(opnd_b))};
            end
            default: alu_res = '0;
        endcase
    end

    always_comb
    begin
        wb_d.reg_wr     = ex_i.ctrl.reg_wr;
        wb_d.mem_to_reg = ex_i.ctrl.mem_to_reg;
        wb_d.mem_wr     = ex_i.ctrl.mem_wr;
        wb_d.dest       = ex_i.ctrl.reg_dst ? ex_i.rd : ex_i.rt;
        wb_d.result     = alu_res;
        wb_d.store_data = rt_val;          // forwarded rt for stores
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wb_o <= '0;
        end
        else
        begin
            wb_o <= wb_d;
        end
    end

endmodule

//--- source/issue_exec_core.sv
// top level of the issue and execute pipeline half, one instruction per clock
`timescale 1ns/1ns

module issue_exec_core
    (
        input  logic                          clk,
        input  logic                          reset,
        input  logic [isa_pkg::INSTR_W-1:0]    instr_i,
        input  logic                          flush_i,
        output logic                          reg_wr_o,
        output logic                          mem_wr_o,
        output logic                          mem_to_reg_o,
        output logic [isa_pkg::REG_ADDR_W-1:0] dest_o,
        output logic [isa_pkg::DATA_W-1:0]     result_o,
        output logic [isa_pkg::DATA_W-1:0]     store_data_o
    );

    import pipe_pkg::*;

    ex_bundle_t issue_ex;   // decoded, before the pipeline register
    ex_bundle_t ex_q;
    wb_bundle_t wb;

    issue_stage u_issue_stage
        (
            .clk     (clk),
            .reset   (reset),
            .instr_i (instr_i),
            .wb_i    (wb),
            .ex_o    (issue_ex)
        );

    ex_pipe_reg u_ex_pipe_reg
        (
            .clk   (clk),
            .reset (reset),
            .clr_i (flush_i),
            .ex_i  (issue_ex),
            .ex_o  (ex_q)
        );

    exec_stage u_exec_stage
        (
            .clk   (clk),
            .reset (reset),
            .ex_i  (ex_q),
            .wb_o  (wb)
        );

    // ----------------------------------------------------------
    // write-back register onto the ports
    // ----------------------------------------------------------
    assign reg_wr_o     = wb.reg_wr;
    assign mem_wr_o     = wb.mem_wr;
    assign mem_to_reg_o = wb.mem_to_reg;
    assign dest_o       = wb.dest;
    assign result_o     = wb.result;
    assign store_data_o = wb.store_data;

endmodule

//--- bench/issue_exec_core_assertions.sv
// concurrent checks on the pipeline control outputs, bound into the core top level
`timescale 1ns/1ns

module issue_exec_core_assertions
    (
        input logic                           clk,
        input logic                           reset,
        input logic                           flush_i,
        input logic                           reg_wr_i,
        input logic                           mem_wr_i,
        input logic                           mem_to_reg_i,
        input logic [isa_pkg::REG_ADDR_W-1:0] dest_i,
        input logic [isa_pkg::DATA_W-1:0]     result_i,
        input logic [isa_pkg::DATA_W-1:0]     rf_r0_i
    );

    // ----------------------------------------------------------
    // control outputs
    // ----------------------------------------------------------
    // first edge after release moves the cleared pipeline register into write-back
    reset_quiet: assert property (@(posedge clk)
        $fell(reset) |=> (!reg_wr_i && !mem_wr_i && !mem_to_reg_i))
        else $error("control outputs active in the first cycle after reset");

    // a write aimed at r0 must leave it zero
    r0_unwritten: assert property (@(posedge clk) disable iff (reset)
        (reg_wr_i && dest_i == '0 && result_i != '0) |=> (rf_r0_i == '0))
        else $error("register 0 changed by a write");

    flush_bubble: assert property (@(posedge clk) disable iff (reset)
        flush_i |-> ##2 (!reg_wr_i && !mem_wr_i && !mem_to_reg_i))   // two edges to outputs
        else $error("flushed instruction reached the control outputs");

endmodule

bind issue_exec_core issue_exec_core_assertions u_assertions
    (
        .clk          (clk),
        .reset        (reset),
        .flush_i      (flush_i),
        .reg_wr_i     (reg_wr_o),
        .mem_wr_i     (mem_wr_o),
        .mem_to_reg_i (mem_to_reg_o),
        .dest_i       (dest_o),
        .result_i     (result_o),
        .rf_r0_i      (u_issue_stage.u_reg_file.regs[0])
    );

//--- bench/issue_exec_core_tb.sv
// testbench for the issue and execute core, applies a table of instructions and checks the outputs
`timescale 1ns/1ns

module issue_exec_core_tb;

    import isa_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int CHECK_DELAY  = 2;   // rising edges from instruction to outputs

    // one table row, stimulus then expected outputs
    typedef struct packed {
        logic [INSTR_W-1:0]    instr;
        logic                  flush;
        logic                  reg_wr;
        logic                  mem_to_reg;
        logic                  mem_wr;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;
        logic [DATA_W-1:0]     store_data;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic [INSTR_W-1:0]    instr;
    logic                  flush;
    logic                  reg_wr;
    logic                  mem_wr;
    logic                  mem_to_reg;
    logic [REG_ADDR_W-1:0] dest;
    logic [DATA_W-1:0]     result;
    logic [DATA_W-1:0]     store_data;

    row_t              rows[$];
    string             names[$];
    logic [DATA_W-1:0] model [REG_COUNT];   // architectural registers as the program sees them
    int                error_count;
    logic              table_ready;

    issue_exec_core u_issue_exec_core
        (
            .clk          (clk),
            .reset        (reset),
            .instr_i      (instr),
            .flush_i      (flush),
            .reg_wr_o     (reg_wr),
            .mem_wr_o     (mem_wr),
            .mem_to_reg_o (mem_to_reg),
            .dest_o       (dest),
            .result_o     (result),
            .store_data_o (store_data)
        );

    // ----------------------------------------------------------
    // encoding and reference model
    // ----------------------------------------------------------
    function automatic logic [INSTR_W-1:0] encode_rtype(funct_e funct, int rs, int rt, int rd);
        return {6'(RTYPE), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(funct)};
    endfunction

    function automatic logic [INSTR_W-1:0] encode_itype(opcode_e op, int rs, int rt, int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [DATA_W-1:0] sign_ext(int imm);
        logic [15:0] imm16;
        imm16 = 16'(imm);
        return {{16{imm16[15]}}, imm16};
    endfunction

    task automatic push_row(input string name, input row_t row);
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic add_rtype(input string name, input funct_e funct, input int rs, input int rt,
                             input int rd);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        row_t              row;
        a   = model[rs];
        b   = model[rt];
        row = '0;
        case (funct)
            ADD:     row.result = a + b;
            SUB:     row.result = a - b;
            AND:     row.result = a & b;
            OR:      row.result = a | b;
            XOR:     row.result = a ^ b;
            SLT:     row.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: row.result = '0;
        endcase
        row.instr      = encode_rtype(funct, rs, rt, rd);
        row.reg_wr     = 1'b1;
        row.dest       = 5'(rd);
        row.store_data = b;
        push_row(name, row);
        if (rd != 0)
            model[rd] = row.result;   // r0 stays zero
    endtask

    // op is one of the immediate ALU opcodes, or LW / SW
    task automatic add_itype(input string name, input opcode_e op, input int rs, input int rt,
                             input int imm);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] simm;
        row_t              row;
        a    = model[rs];
        simm = sign_ext(imm);
        row  = '0;
        case (op)
            ANDI:    row.result = a & simm;
            ORI:     row.result = a | simm;
            SLTI:    row.result = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            default: row.result = a + simm;   // addi and the memory address
        endcase
        row.instr      = encode_itype(op, rs, rt, imm);
        row.reg_wr     = (op != SW);
        row.mem_to_reg = (op == LW);
        row.mem_wr     = (op == SW);
        row.dest       = 5'(rt);
        row.store_data = model[rt];
        push_row(name, row);
        if (row.reg_wr && !row.mem_to_reg && rt != 0)
            model[rt] = row.result;
    endtask

    // dropped by the flush, so the model does not change
    task automatic add_flushed(input string name, input logic [INSTR_W-1:0] word);
        row_t row;
        row       = '0;
        row.instr = word;
        row.flush = 1'b1;
        push_row(name, row);
    endtask

    task automatic build_table();
        int rnd;
        for (int i = 0; i < REG_COUNT; i++)
            model[i] = '0;
        add_rtype("reset_read", ADD, 1, 2, 3);
        add_itype("addi", ADDI, 0, 1, 16'h0123);
        add_itype("addi_neg", ADDI, 0, 2, -5);
        add_itype("andi", ANDI, 2, 4, 16'h8f0f);
        add_itype("ori", ORI, 1, 5, 16'h8000);
        add_itype("slti_true", SLTI, 2, 6, 1);
        add_itype("slti_false", SLTI, 1, 7, -1);
        add_rtype("add", ADD, 1, 2, 8);
        add_rtype("sub_fwd", SUB, 8, 1, 9);
        add_rtype("and_fwd_bypass", AND, 9, 8, 10);
        add_rtype("or", OR, 4, 5, 11);
        add_rtype("xor", XOR, 11, 2, 12);
        add_rtype("slt_neg", SLT, 2, 1, 13);
        add_rtype("slt_pos", SLT, 1, 2, 14);
        add_itype("addi_for_sw", ADDI, 0, 15, 16'h0077);
        add_itype("sw_fwd_data", SW, 1, 15, 4);
        add_itype("lw", LW, 1, 16, 16'h0010);
        add_rtype("after_lw", ADD, 16, 0, 17);
        add_rtype("after_lw_2", OR, 0, 16, 18);
        add_flushed("flushed_addi", encode_itype(ADDI, 0, 1, 16'h0055));
        add_rtype("after_flush", ADD, 1, 0, 19);
        add_itype("write_r0", ADDI, 1, 0, 7);
        add_rtype("r0_next", ADD, 0, 0, 20);
        add_rtype("r0_bypass", ADD, 0, 1, 21);
        // random immediates, results follow from the model
        rnd = $urandom();
        add_itype("rand_addi", ADDI, 1, 22, rnd);
        rnd = $urandom();
        add_itype("rand_ori", ORI, 22, 23, rnd);
        rnd = $urandom();
        add_itype("rand_slti", SLTI, 23, 24, rnd);
        add_rtype("rand_xor", XOR, 23, 22, 25);
        rnd = $urandom();
        add_itype("rand_andi", ANDI, 25, 26, rnd);
    endtask

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    task automatic check_row(input int idx);
        row_t  row;
        string name;
        row  = rows[idx];
        name = names[idx];
        if (reg_wr !== row.reg_wr)
        begin
            $display("error %s: reg_wr expected %0b actual %0b", name, row.reg_wr, reg_wr);
            error_count++;
        end
        if (mem_wr !== row.mem_wr)
        begin
            $display("error %s: mem_wr expected %0b actual %0b", name, row.mem_wr, mem_wr);
            error_count++;
        end
        if (mem_to_reg !== row.mem_to_reg)
        begin
            $display("error %s: mem_to_reg expected %0b actual %0b", name, row.mem_to_reg,
                     mem_to_reg);
            error_count++;
        end
        if (dest !== row.dest)
        begin
            $display("error %s: dest expected %0d actual %0d", name, row.dest, dest);
            error_count++;
        end
        if (result !== row.result)
        begin
            $display("error %s: result expected %h actual %h", name, row.result, result);
            error_count++;
        end
        if (store_data !== row.store_data)
        begin
            $display("error %s: store_data expected %h actual %h", name, row.store_data,
                     store_data);
            error_count++;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        int seed;
        seed        = 44;
        void'($urandom(seed));
        reset       = 1'b1;
        instr       = '0;
        flush       = 1'b0;
        error_count = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (reg_wr !== 1'b0 || mem_wr !== 1'b0 || mem_to_reg !== 1'b0)
        begin
            $display("error reset: controls expected 000 actual %b%b%b", reg_wr, mem_wr,
                     mem_to_reg);
            error_count++;
        end

        // each row is checked two negedges after it was driven
        for (int i = 0; i < rows.size() + CHECK_DELAY; i++)
        begin
            if (i >= CHECK_DELAY)
                check_row(i - CHECK_DELAY);
            if (i < rows.size())
            begin
                instr = rows[i].instr;
                flush = rows[i].flush;
            end
            else
            begin
                instr = '0;
                flush = 1'b0;
            end
            @(negedge clk);
        end

        $display("checks done, rows %0d, errors %0d", rows.size(), error_count);
        if (error_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("timeout: the instruction table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- vlog.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/issue_stage.sv
source/ex_pipe_reg.sv
source/exec_stage.sv
source/issue_exec_core.sv
bench/issue_exec_core_assertions.sv
bench/issue_exec_core_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status follows the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module issue_exec_core_tb

# a failing run still has its output searched
out=$(./obj_dir/Vissue_exec_core_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
